// File: hdl/pkt_match_pkg.sv
`default_nettype none

package pkt_match_pkg;

  // Bytes per data word
  localparam int WORD_BYTES = 8;

  // Bytes in the type field
  localparam int TYPE_BYTES = 4;

  // Type field must sit inside one word, so the last legal start is 4
  localparam int TYPE_MAX_OFF = WORD_BYTES - TYPE_BYTES;

  // One data word, byte i at bits 8i+7:8i
  typedef logic [8*WORD_BYTES-1:0] data_t;

  // Index of the last valid byte, 7 is a full word
  typedef logic [$clog2(WORD_BYTES)-1:0] last_byte_t;

  // Byte position inside a word
  typedef logic [$clog2(WORD_BYTES)-1:0] byte_off_t;

  // Word index inside a packet, wraps on long packets
  typedef logic [3:0] word_off_t;

  // Result tag returned on the eop word
  typedef logic [15:0] buffer_t;

  // Type pattern, byte j compared against data byte off+j
  typedef logic [8*TYPE_BYTES-1:0] type_pat_t;

  // Word as seen at the input and through the pipeline
  typedef struct packed {
    logic       sop;
    logic       eop;
    last_byte_t last_byte;
    data_t      data;
  } pkt_word_t;

  // Where the type field sits in the packet
  typedef struct packed {
    word_off_t word;
    byte_off_t off;
  } type_sel_t;

  // One symbol entry
  typedef struct packed {
    logic      valid;
    word_off_t off;
    data_t     pattern;
    buffer_t   buffer;
  } sym_match_t;

  // Egress word with the resolved tag
  typedef struct packed {
    pkt_word_t word;
    buffer_t   buffer;
  } out_word_t;

  // Compare stage result, per word
  typedef struct packed {
    pkt_word_t word;
    logic      first;
    logic      type_found;
    logic      sym_found;
    buffer_t   sym_buffer;
  } cmp_word_t;

  // Packet framing FSM
  typedef enum logic [0:0] {
    IDLE      = 1'b0,
    IN_PACKET = 1'b1
  } pkt_state_t;

  // Thermometer mask of the valid bytes, bit i set for i <= last_byte
  function automatic logic [WORD_BYTES-1:0] last_byte_mask(last_byte_t last_byte);
    logic [WORD_BYTES-1:0] mask;
    for (int i = 0; i < WORD_BYTES; i++) begin
      mask[i] = (i <= int'(last_byte));
    end
    return mask;
  endfunction

endpackage

`default_nettype wire

// File: hdl/pkt_ingress.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_ingress
  import pkt_match_pkg::*;
#(
  parameter int N_SYMBOLS = 1
) (
  input  logic                         clk_net,
  input  logic                         rst_net,
  // Raw network side
  input  logic                         in_vld,
  input  pkt_word_t                    in_word,
  // Operands, sampled on sop
  input  type_sel_t                    type_sel,
  input  type_pat_t                    type_pat,
  input  sym_match_t [N_SYMBOLS-1:0]   symbols,
  // To compare stage
  output logic                         ing_vld,
  output pkt_word_t                    ing_word,
  output logic                         ing_first,
  output word_off_t                    ing_off,
  output type_sel_t                    lat_type_sel,
  output type_pat_t                    lat_type_pat,
  output sym_match_t [N_SYMBOLS-1:0]   lat_symbols
);

  pkt_state_t state_r;
  pkt_state_t state_nxt;
  logic       sop_in;
  logic       accept;
  word_off_t  off_nxt;

  always_comb begin
    // A valid sop always starts a new packet
    sop_in    = in_vld & in_word.sop;
    accept    = 1'b0;
    state_nxt = state_r;

    case (state_r)
      IDLE: begin
        // Only a sop word gets us out of idle, anything else is dropped
        if (sop_in) begin
          accept = 1'b1;
          // Single word packets stay in idle
          if (!in_word.eop) begin
            state_nxt = IN_PACKET;
          end
        end
      end
      IN_PACKET: begin
        // Body and tail words
        if (in_vld) begin
          accept = 1'b1;
          if (in_word.eop) begin
            state_nxt = IDLE;
          end
        end
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase

    // Word index restarts at zero on sop
    off_nxt = in_word.sop ? '0 : ing_off + word_off_t'(1);
  end

  // Framing state
  always_ff @(posedge clk_net) begin
    if (rst_net) begin
      state_r <= IDLE;
    end else begin
      state_r <= state_nxt;
    end
  end

  // Stage valid, first flag and word counter
  always_ff @(posedge clk_net) begin
    if (rst_net) begin
      ing_vld   <= 1'b0;
      ing_first <= 1'b0;
      ing_off   <= '0;
    end else begin
      ing_vld   <= accept;
      ing_first <= accept & in_word.sop;
      if (accept) begin
        ing_off <= off_nxt;
      end
    end
  end

  // Word payload
  always_ff @(posedge clk_net) begin
    if (accept) begin
      ing_word <= in_word;
    end
  end

  // Operands held for the whole packet, lined up with the sop word
  always_ff @(posedge clk_net) begin
    if (sop_in) begin
      lat_type_sel <= type_sel;
      lat_type_pat <= type_pat;
      lat_symbols  <= symbols;
    end
  end

endmodule

`default_nettype wire

// File: hdl/field_compare.sv
`timescale 1ns/1ps
`default_nettype none

module field_compare
  import pkt_match_pkg::*;
#(
  parameter int N_SYMBOLS = 1
) (
  input  logic                         clk_net,
  input  logic                         rst_net,
  // From ingress
  input  logic                         ing_vld,
  input  pkt_word_t                    ing_word,
  input  logic                         ing_first,
  input  word_off_t                    ing_off,
  input  type_sel_t                    lat_type_sel,
  input  type_pat_t                    lat_type_pat,
  input  sym_match_t [N_SYMBOLS-1:0]   lat_symbols,
  // To resolve stage
  output logic                         cmp_vld,
  output cmp_word_t                    cmp_word
);

  logic [WORD_BYTES-1:0] valid_mask;
  logic [WORD_BYTES-1:0] type_pos;
  logic                  type_in_word;
  logic                  type_off_ok;
  logic                  type_found;
  logic                  full_word;
  logic                  sym_hit;
  buffer_t               sym_buf;
  logic                  sym_found;

  // Type search
  always_comb begin
    // Length only limits the tail word
    valid_mask = ing_word.eop ? last_byte_mask(ing_word.last_byte) : '1;

    // One comparator per legal start byte
    type_pos = '0;
    for (int i = 0; i <= TYPE_MAX_OFF; i++) begin
      type_pos[i] = 1'b1;
      for (int j = 0; j < TYPE_BYTES; j++) begin
        // Byte must be present and equal
        if (!valid_mask[i+j] ||
            (lat_type_pat[8*j +: 8] != ing_word.data[8*(i+j) +: 8])) begin
          type_pos[i] = 1'b0;
        end
      end
    end

    type_in_word = (ing_off == lat_type_sel.word);
    // Starts past TYPE_MAX_OFF would straddle two words
    type_off_ok  = (int'(lat_type_sel.off) <= TYPE_MAX_OFF);
    type_found   = ing_vld & type_in_word & type_off_ok & type_pos[lat_type_sel.off];
  end

  // Symbol search
  always_comb begin
    // A symbol fills the whole word, so a short tail cannot hold one
    full_word = ~ing_word.eop | (ing_word.last_byte == last_byte_t'(WORD_BYTES - 1));

    sym_hit = 1'b0;
    sym_buf = '0;
    // Later entries override earlier ones, highest index wins
    for (int k = 0; k < N_SYMBOLS; k++) begin
      if (lat_symbols[k].valid &&
          (lat_symbols[k].off == ing_off) &&
          (lat_symbols[k].pattern == ing_word.data)) begin
        sym_hit = 1'b1;
        sym_buf = lat_symbols[k].buffer;
      end
    end

    sym_found = ing_vld & full_word & sym_hit;
  end

  // Stage valid
  always_ff @(posedge clk_net) begin
    if (rst_net) begin
      cmp_vld <= 1'b0;
    end else begin
      cmp_vld <= ing_vld;
    end
  end

  // Word travels on with its per-word results
  always_ff @(posedge clk_net) begin
    if (ing_vld) begin
      cmp_word.word       <= ing_word;
      cmp_word.first      <= ing_first;
      cmp_word.type_found <= type_found;
      cmp_word.sym_found  <= sym_found;
      cmp_word.sym_buffer <= sym_buf;
    end
  end

endmodule

`default_nettype wire

// File: hdl/match_resolve.sv
`timescale 1ns/1ps
`default_nettype none

module match_resolve
  import pkt_match_pkg::*;
(
  input  logic      clk_net,
  input  logic      rst_net,
  // From compare stage
  input  logic      cmp_vld,
  input  cmp_word_t cmp_word,
  // Egress
  output logic      out_vld,
  output out_word_t out_word
);

  // Per packet match status
  logic    got_type_r;
  logic    got_symbol_r;
  buffer_t buffer_r;

  logic    base_type;
  logic    base_symbol;
  buffer_t base_buffer;
  logic    got_type_nxt;
  logic    got_symbol_nxt;
  buffer_t buffer_nxt;
  logic    hit;

  always_comb begin
    // First word of a packet starts from a clean slate
    base_type   = cmp_word.first ? 1'b0 : got_type_r;
    base_symbol = cmp_word.first ? 1'b0 : got_symbol_r;
    base_buffer = cmp_word.first ? '0 : buffer_r;

    // Merge this word's findings
    got_type_nxt   = base_type | cmp_word.type_found;
    got_symbol_nxt = base_symbol | cmp_word.sym_found;
    // Most recent symbol match supplies the tag
    buffer_nxt     = cmp_word.sym_found ? cmp_word.sym_buffer : base_buffer;

    // Tag is only released on the tail, and only with both fields seen
    hit = cmp_word.word.eop & got_type_nxt & got_symbol_nxt;
  end

  // Match status
  always_ff @(posedge clk_net) begin
    if (rst_net) begin
      got_type_r   <= 1'b0;
      got_symbol_r <= 1'b0;
      buffer_r     <= '0;
    end else if (cmp_vld) begin
      got_type_r   <= got_type_nxt;
      got_symbol_r <= got_symbol_nxt;
      buffer_r     <= buffer_nxt;
    end
  end

  // Output valid
  always_ff @(posedge clk_net) begin
    if (rst_net) begin
      out_vld <= 1'b0;
    end else begin
      out_vld <= cmp_vld;
    end
  end

  // Output word, forwarded as is apart from the tag
  always_ff @(posedge clk_net) begin
    if (cmp_vld) begin
      out_word.word   <= cmp_word.word;
      out_word.buffer <= hit ? buffer_nxt : '0;
    end
  end

endmodule

`default_nettype wire

// File: hdl/pkt_match_top.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_match_top
  import pkt_match_pkg::*;
#(
  parameter int N_SYMBOLS = 4
) (
  input  logic                         clk_net,
  input  logic                         rst_net,
  // Network words
  input  logic                         in_vld,
  input  pkt_word_t                    in_word,
  // Match operands
  input  type_sel_t                    type_sel,
  input  type_pat_t                    type_pat,
  input  sym_match_t [N_SYMBOLS-1:0]   symbols,
  // Tagged words out
  output logic                         out_vld,
  output out_word_t                    out_word
);

  // Ingress to compare
  logic                       ing_vld;
  pkt_word_t                  ing_word;
  logic                       ing_first;
  word_off_t                  ing_off;
  type_sel_t                  lat_type_sel;
  type_pat_t                  lat_type_pat;
  sym_match_t [N_SYMBOLS-1:0] lat_symbols;

  // Compare to resolve
  logic                       cmp_vld;
  cmp_word_t                  cmp_word;

  // Framing, counter and operand capture
  pkt_ingress #(
    .N_SYMBOLS (N_SYMBOLS)
  ) u_ingress (
    .clk_net      (clk_net),
    .rst_net      (rst_net),
    .in_vld       (in_vld),
    .in_word      (in_word),
    .type_sel     (type_sel),
    .type_pat     (type_pat),
    .symbols      (symbols),
    .ing_vld      (ing_vld),
    .ing_word     (ing_word),
    .ing_first    (ing_first),
    .ing_off      (ing_off),
    .lat_type_sel (lat_type_sel),
    .lat_type_pat (lat_type_pat),
    .lat_symbols  (lat_symbols)
  );

  // Per word type and symbol comparators
  field_compare #(
    .N_SYMBOLS (N_SYMBOLS)
  ) u_compare (
    .clk_net      (clk_net),
    .rst_net      (rst_net),
    .ing_vld      (ing_vld),
    .ing_word     (ing_word),
    .ing_first    (ing_first),
    .ing_off      (ing_off),
    .lat_type_sel (lat_type_sel),
    .lat_type_pat (lat_type_pat),
    .lat_symbols  (lat_symbols),
    .cmp_vld      (cmp_vld),
    .cmp_word     (cmp_word)
  );

  // Packet level decision
  match_resolve u_resolve (
    .clk_net  (clk_net),
    .rst_net  (rst_net),
    .cmp_vld  (cmp_vld),
    .cmp_word (cmp_word),
    .out_vld  (out_vld),
    .out_word (out_word)
  );

endmodule

`default_nettype wire

// File: test/tb_pkt_match.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pkt_match
  import pkt_match_pkg::*;
();

  localparam int N_SYMBOLS  = 4;
  localparam int CLK_PERIOD = 100;
  localparam int MAX_WORDS  = 6;
  localparam int MAX_GAP    = 3;
  localparam int RAND_PKTS  = 40;
  localparam int EDGE_REPS  = 10;
  // Two random tests, then five edge, two priority, two framing and one burst packet per rep
  localparam int TOTAL_PKTS = 2 * RAND_PKTS + 10 * EDGE_REPS;
  // Worst case cycles for one packet, every word behind a full idle gap
  localparam int PKT_CYCLES = MAX_WORDS * (MAX_GAP + 1) + MAX_GAP;
  localparam int WATCH_NS   = (TOTAL_PKTS * PKT_CYCLES + 500) * CLK_PERIOD;

  logic                       clk_net;
  logic                       rst_net;
  logic                       in_vld;
  pkt_word_t                  in_word;
  type_sel_t                  type_sel;
  type_pat_t                  type_pat;
  sym_match_t [N_SYMBOLS-1:0] symbols;
  logic                       out_vld;
  out_word_t                  out_word;

  // Packet under construction and the operands that go with its sop
  data_t                      pkt_data [16];
  int                         pkt_len;
  last_byte_t                 pkt_last;
  type_sel_t                  tsel_r;
  type_pat_t                  tpat_r;
  sym_match_t [N_SYMBOLS-1:0] syms_r;

  // Reference model state
  logic                       m_in_pkt;
  word_off_t                  m_cnt;
  type_sel_t                  m_tsel;
  type_pat_t                  m_tpat;
  sym_match_t [N_SYMBOLS-1:0] m_syms;
  logic                       m_got_type;
  logic                       m_got_sym;
  buffer_t                    m_buf;

  // Expected words and the cycle each one is due
  out_word_t                  exp_q [$];
  int                         exp_cyc_q [$];
  int                         cyc = 0;
  int                         err_cnt = 0;
  int                         chk_cnt = 0;
  int                         hit_cnt = 0;

  pkt_match_top #(
    .N_SYMBOLS (N_SYMBOLS)
  ) uut (
    .clk_net  (clk_net),
    .rst_net  (rst_net),
    .in_vld   (in_vld),
    .in_word  (in_word),
    .type_sel (type_sel),
    .type_pat (type_pat),
    .symbols  (symbols),
    .out_vld  (out_vld),
    .out_word (out_word)
  );

  initial begin
    clk_net = 1'b0;
    forever #(CLK_PERIOD / 2) clk_net = ~clk_net;
  end

  always @(posedge clk_net) begin
    cyc <= cyc + 1;
  end

  function automatic data_t rand_data();
    return {$urandom, $urandom};
  endfunction

  function automatic pkt_word_t rand_pkt_word();
    pkt_word_t w;
    w.sop       = 1'($urandom);
    w.eop       = 1'($urandom);
    w.last_byte = last_byte_t'($urandom);
    w.data      = rand_data();
    return w;
  endfunction

  function automatic int rand_len();
    return 1 + int'($urandom_range(MAX_WORDS - 1, 0));
  endfunction

  function automatic int rand_word();
    return int'($urandom_range(pkt_len - 1, 0));
  endfunction

  function automatic int rand_off();
    return int'($urandom_range(TYPE_MAX_OFF, 0));
  endfunction

  function automatic int rand_sym();
    return int'($urandom_range(N_SYMBOLS - 1, 0));
  endfunction

  // Expected result of one valid input word, straight from the matching rules
  task automatic model_step(input pkt_word_t w);
    out_word_t exp_w;
    logic      type_hit;
    logic      sym_hit;
    buffer_t   sym_buf;
    int        o;
    // Outside a packet only a sop is taken
    if (m_in_pkt || w.sop) begin
      if (w.sop) begin
        m_cnt      = '0;
        m_tsel     = type_sel;
        m_tpat     = type_pat;
        m_syms     = symbols;
        m_got_type = 1'b0;
        m_got_sym  = 1'b0;
        m_buf      = '0;
      end else begin
        m_cnt = m_cnt + 4'd1;
      end
      // Type needs the right word, a start that fits and four present equal bytes
      o        = int'(m_tsel.off);
      type_hit = (m_cnt == m_tsel.word) && (o <= TYPE_MAX_OFF);
      if (type_hit) begin
        for (int j = 0; j < TYPE_BYTES; j++) begin
          if (w.eop && (o + j > int'(w.last_byte))) begin
            type_hit = 1'b0;
          end
          if (w.data[8*(o+j) +: 8] != m_tpat[8*j +: 8]) begin
            type_hit = 1'b0;
          end
        end
      end
      // Symbols only on full words, last matching entry in index order wins
      sym_hit = 1'b0;
      sym_buf = '0;
      if (!w.eop || (w.last_byte == last_byte_t'(7))) begin
        for (int k = 0; k < N_SYMBOLS; k++) begin
          if (m_syms[k].valid && (m_syms[k].off == m_cnt) && (m_syms[k].pattern == w.data)) begin
            sym_hit = 1'b1;
            sym_buf = m_syms[k].buffer;
          end
        end
      end
      m_got_type = m_got_type | type_hit;
      m_got_sym  = m_got_sym | sym_hit;
      if (sym_hit) begin
        m_buf = sym_buf;
      end
      exp_w.word   = w;
      exp_w.buffer = (w.eop && m_got_type && m_got_sym) ? m_buf : '0;
      if (exp_w.buffer != '0) begin
        hit_cnt++;
      end
      m_in_pkt = !w.eop;
      exp_q.push_back(exp_w);
      // Three register stages after the drive cycle
      exp_cyc_q.push_back(cyc + 3);
    end
  endtask

  // One cycle of input, operands are junk except on a packet's first word
  task automatic drive_word(input logic vld, input pkt_word_t w, input logic load_ops);
    @(posedge clk_net);
    #1;
    in_vld  = vld;
    in_word = w;
    if (load_ops) begin
      type_sel = tsel_r;
      type_pat = tpat_r;
      symbols  = syms_r;
    end else begin
      type_sel = type_sel_t'($urandom);
      type_pat = $urandom;
      for (int k = 0; k < N_SYMBOLS; k++) begin
        symbols[k] = {1'($urandom), word_off_t'($urandom), rand_data(), buffer_t'($urandom)};
      end
    end
    if (vld) begin
      model_step(w);
    end
  endtask

  // Random payload and operands that almost surely match nothing
  task automatic new_packet(input int n, input last_byte_t lb);
    pkt_len  = n;
    pkt_last = lb;
    for (int i = 0; i < n; i++) begin
      pkt_data[i] = rand_data();
    end
    tsel_r = type_sel_t'($urandom);
    tpat_r = $urandom;
    for (int k = 0; k < N_SYMBOLS; k++) begin
      syms_r[k] = {1'($urandom), word_off_t'($urandom), rand_data(), buffer_t'($urandom)};
    end
  endtask

  // Bytes past the word end are not written
  task automatic plant_type(input int word, input int off);
    tsel_r.word = word_off_t'(word);
    tsel_r.off  = byte_off_t'(off);
    for (int j = 0; j < TYPE_BYTES; j++) begin
      if (off + j < WORD_BYTES) begin
        pkt_data[word][8*(off+j) +: 8] = tpat_r[8*j +: 8];
      end
    end
  endtask

  task automatic plant_sym(input int k, input int word);
    syms_r[k].valid   = 1'b1;
    syms_r[k].off     = word_off_t'(word);
    syms_r[k].pattern = pkt_data[word];
    syms_r[k].buffer  = buffer_t'($urandom_range(16'hffff, 1));
  endtask

  task automatic send_packet(input int gap_max);
    pkt_word_t w;
    int        gaps;
    for (int i = 0; i < pkt_len; i++) begin
      gaps = int'($urandom_range(gap_max, 0));
      repeat (gaps) begin
        drive_word(1'b0, rand_pkt_word(), 1'b0);
      end
      w.sop       = (i == 0);
      w.eop       = (i == pkt_len - 1);
      // Length field only means something on the tail
      w.last_byte = (i == pkt_len - 1) ? pkt_last : last_byte_t'($urandom);
      w.data      = pkt_data[i];
      drive_word(1'b1, w, i == 0);
    end
  endtask

  task automatic finish_test(input string name, input int e0);
    drive_word(1'b0, rand_pkt_word(), 1'b0);
    while (exp_q.size() != 0) begin
      @(negedge clk_net);
    end
    // A few quiet cycles catch stray outputs
    repeat (4) @(negedge clk_net);
    $display("test %-14s done, %0d errors", name, err_cnt - e0);
  endtask

  // Outputs sampled mid cycle against the model queue
  always @(negedge clk_net) begin : check_out
    out_word_t exp_w;
    int        ecyc;
    if (!rst_net) begin
      if (out_vld) begin
        if (exp_q.size() == 0) begin
          $display("Output word at cycle %0d with no input word pending", cyc);
          err_cnt++;
        end else begin
          exp_w = exp_q.pop_front();
          ecyc  = exp_cyc_q.pop_front();
          chk_cnt++;
          if (ecyc != cyc) begin
            $display("CHECK FAILED out_vld cycle exp %h got %h", ecyc, cyc);
            err_cnt++;
          end
          if (out_word.word != exp_w.word) begin
            $display("CHECK FAILED out_word.word exp %h got %h", exp_w.word, out_word.word);
            err_cnt++;
          end
          if (out_word.buffer != exp_w.buffer) begin
            $display("CHECK FAILED out_word.buffer exp %h got %h", exp_w.buffer, out_word.buffer);
            err_cnt++;
          end
        end
      end else if ((exp_cyc_q.size() != 0) && (exp_cyc_q[0] <= cyc)) begin
        $display("Output word due at cycle %0d never appeared", exp_cyc_q[0]);
        err_cnt++;
        void'(exp_q.pop_front());
        void'(exp_cyc_q.pop_front());
      end
    end
  end

  initial begin
    #(WATCH_NS);
    $display("Timeout, the run did not end within %0d ns", WATCH_NS);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin : main_seq
    int        e0;
    int        mode;
    int        lb;
    int        w;
    int        k;
    pkt_word_t stray;
    void'($urandom(32'he471));
    rst_net    = 1'b1;
    in_vld     = 1'b0;
    in_word    = '0;
    type_sel   = '0;
    type_pat   = '0;
    symbols    = '0;
    m_in_pkt   = 1'b0;
    m_cnt      = '0;
    m_tsel     = '0;
    m_tpat     = '0;
    m_syms     = '0;
    m_got_type = 1'b0;
    m_got_sym  = 1'b0;
    m_buf      = '0;
    repeat (2) @(posedge clk_net);
    #1;
    rst_net = 1'b0;

    // Plain forwarding with idle gaps
    e0 = err_cnt;
    repeat (RAND_PKTS) begin
      new_packet(rand_len(), last_byte_t'($urandom));
      send_packet(MAX_GAP);
    end
    finish_test("pass_through", e0);

    // Both fields, type only, symbol only
    e0 = err_cnt;
    repeat (RAND_PKTS) begin
      mode = int'($urandom_range(2, 0));
      new_packet(rand_len(), last_byte_t'(7));
      if (mode != 2) begin
        plant_type(rand_word(), rand_off());
      end
      if (mode != 1) begin
        plant_sym(rand_sym(), rand_word());
      end
      send_packet(MAX_GAP);
    end
    finish_test("type_and_symbol", e0);

    e0 = err_cnt;
    repeat (EDGE_REPS) begin
      for (int c = 0; c < 5; c++) begin
        case (c)
          0: begin
            // Start past the last legal offset
            new_packet(rand_len(), last_byte_t'(7));
            plant_type(rand_word(), TYPE_MAX_OFF + 1 + int'($urandom_range(2, 0)));
            plant_sym(rand_sym(), rand_word());
          end
          1: begin
            // Type runs past last_byte of the tail
            lb = int'($urandom_range(6, 0));
            new_packet(2 + int'($urandom_range(MAX_WORDS - 2, 0)), last_byte_t'(lb));
            plant_type(pkt_len - 1, int'($urandom_range(TYPE_MAX_OFF, (lb > 2) ? lb - 2 : 0)));
            plant_sym(rand_sym(), 0);
          end
          2: begin
            // Symbol sits on a short tail
            new_packet(2 + int'($urandom_range(MAX_WORDS - 2, 0)), last_byte_t'($urandom_range(6, 0)));
            plant_type(0, rand_off());
            plant_sym(rand_sym(), pkt_len - 1);
          end
          3: begin
            new_packet(rand_len(), last_byte_t'(7));
            plant_type(rand_word(), rand_off());
            k = rand_sym();
            plant_sym(k, rand_word());
            syms_r[k].valid = 1'b0;
          end
          default: begin
            // Single word packet carrying both fields
            new_packet(1, last_byte_t'(7));
            plant_type(0, rand_off());
            plant_sym(rand_sym(), 0);
          end
        endcase
        send_packet(MAX_GAP);
      end
    end
    finish_test("edge_rules", e0);

    e0 = err_cnt;
    repeat (EDGE_REPS) begin
      // Two entries on one word
      new_packet(rand_len(), last_byte_t'(7));
      plant_type(rand_word(), rand_off());
      w = rand_word();
      k = int'($urandom_range(N_SYMBOLS - 2, 0));
      plant_sym(k, w);
      plant_sym(k + 1 + int'($urandom_range(N_SYMBOLS - 2 - k, 0)), w);
      send_packet(MAX_GAP);
      // Later word wins even with the lower index
      new_packet(2 + int'($urandom_range(MAX_WORDS - 2, 0)), last_byte_t'(7));
      plant_type(rand_word(), rand_off());
      w = int'($urandom_range(pkt_len - 2, 0));
      plant_sym(N_SYMBOLS - 1, w);
      plant_sym(0, w + 1 + int'($urandom_range(pkt_len - 2 - w, 0)));
      send_packet(MAX_GAP);
    end
    finish_test("priority", e0);

    e0 = err_cnt;
    repeat (EDGE_REPS) begin
      // Stray valid words while idle
      repeat (1 + int'($urandom_range(2, 0))) begin
        stray     = rand_pkt_word();
        stray.sop = 1'b0;
        drive_word(1'b1, stray, 1'b0);
      end
      // Hit packet straight into a symbol only packet
      new_packet(rand_len(), last_byte_t'(7));
      plant_type(rand_word(), rand_off());
      plant_sym(rand_sym(), rand_word());
      send_packet(0);
      new_packet(rand_len(), last_byte_t'(7));
      plant_sym(rand_sym(), rand_word());
      send_packet(0);
    end
    finish_test("framing", e0);

    // Back to back burst, cycle checks done by the monitor
    e0 = err_cnt;
    repeat (EDGE_REPS) begin
      new_packet(rand_len(), last_byte_t'($urandom));
      if (1'($urandom)) begin
        pkt_last = last_byte_t'(7);
        plant_type(rand_word(), rand_off());
        plant_sym(rand_sym(), rand_word());
      end
      send_packet(0);
    end
    finish_test("latency", e0);

    $display("%0d words checked, %0d tagged, %0d errors", chk_cnt, hit_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
hdl/pkt_match_pkg.sv
hdl/pkt_ingress.sv
hdl/field_compare.sv
hdl/match_resolve.sv
hdl/pkt_match_top.sv
test/tb_pkt_match.sv

// File: Makefile
TOP := tb_pkt_match

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module pkt_match_top

sim:
	verilator --binary --timing -f vlog.f --top-module $(TOP) --Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q '^\*\*\* PASSED \*\*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log
